// File: sim.f
+incdir+logic
logic/ifx_isa_pkg.sv
logic/ifx_pipe_pkg.sv
logic/ifx_apb_front.sv
logic/ifx_ins_queue.sv
logic/ifx_extract_mux.sv
logic/ifx_top.sv
tb/ifx_clock_gen.sv
tb/ifx_tb.sv

// File: Makefile
# Verilator build and run for the instruction extract testbench

VERILATOR  ?= verilator
TOP        := ifx_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

# The run fails unless the pass message shows up as a line of its own
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/ifx_tb.sv
// Instruction extract testbench
// Applies a table of APB accesses to the top level, builds the expected
// instruction stream from the same rows and checks ins under random stalls

`default_nettype none

`include "ifx_settings.svh"

module ifx_tb
	import ifx_isa_pkg::*;
	import ifx_pipe_pkg::*;
();
	typedef enum logic [2:0] {
		K_WR, K_RD, K_WR_STALL, K_EN, K_DRAIN, K_DONE
	} kind_e;

	// Control rows of the table use only the data field
	typedef struct packed {
		kind_e       kind;
		apb_addr_t   addr;
		logic [31:0] data;
		logic        exp_err;
		logic [31:0] exp_rdata;
		logic        check_data;
	} row_t;

	localparam logic [31:0] EN_LOW = 32'd0;
	localparam logic [31:0] EN_HIGH = 32'd1;
	localparam logic [31:0] EN_RAND = 32'd2;
	localparam int STALL_CYCLES = 8;

	logic          clk;
	logic          rst;
	apb_req_t      apb;
	logic          en;
	apb_rsp_t      apb_rsp;
	pipeline_reg_t ins;

	row_t          rows[$];
	pipeline_reg_t exp_ins[$];
	pipeline_reg_t exp_irq[$];
	string         test_names[7];
	pc_t           model_pc;
	logic [1:0]    en_mode;
	logic [15:0]   lfsr;
	logic          en_at_edge;
	int            errors = 0;
	int            errors_before = 0;
	int            tests_run = 0;
	int            tests_bad = 0;
	int            cycles = 0;
	int            cycle_limit = 0;

	ifx_clock_gen i_ifx_clock_gen (
		.clk, .rst
	);

	ifx_top i_ifx_top (
		.clk, .rst, .apb, .en, .apb_rsp, .ins
	);

	// ====================
	// Helpers
	// ====================

	// Taps 16, 14, 13 and 11 with the new bit entering at bit 0
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Word layout is imm[31:17] ra[16:12] rt[11:7] opcode[6:0]
	function automatic ins_word_t pack_word(input logic [6:0] op, input reg_t rt,
		input reg_t ra, input imm_t imm);
		return {imm, ra, rt, op};
	endfunction

	task automatic report_err(input string msg);
		$display("ERR %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_ins(input pipeline_reg_t got, input pipeline_reg_t exp,
		input string what);
		if (got !== exp)
			report_err($sformatf("%s got pc %h word %h rt %0d ra %0d v%b nop%b mc%b, %s",
				what, got.pc, got.ins, got.rt, got.ra, got.v, got.nop, got.mc,
				$sformatf("expected pc %h word %h rt %0d ra %0d v%b nop%b mc%b",
				exp.pc, exp.ins, exp.rt, exp.ra, exp.v, exp.nop, exp.mc)));
	endtask

	task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp,
		input logic check_data, input string what);
		if (got.pslverr !== exp.pslverr || (check_data && got.prdata !== exp.prdata))
			report_err($sformatf("%s got pslverr %b prdata %h, expected pslverr %b prdata %h",
				what, got.pslverr, got.prdata, exp.pslverr, exp.prdata));
	endtask

	task automatic write_row(input kind_e k, input apb_addr_t a, input logic [31:0] d,
		input logic err);
		rows.push_back('{kind: k, addr: a, data: d, exp_err: err, exp_rdata: '0,
			check_data: 1'b0});
	endtask

	task automatic read_row(input apb_addr_t a, input logic err, input logic [31:0] rd,
		input logic chk);
		rows.push_back('{kind: K_RD, addr: a, data: '0, exp_err: err, exp_rdata: rd,
			check_data: chk});
	endtask

	task automatic control_row(input kind_e k, input logic [31:0] d);
		rows.push_back('{kind: k, addr: '0, data: d, exp_err: 1'b0, exp_rdata: '0,
			check_data: 1'b0});
	endtask

	// ====================
	// Expected stream
	// ====================

	// Builds what the extract stage should emit for one applied row
	task automatic model_apply(input row_t r);
		pipeline_reg_t e;
		reg_mask_t     mask;
		int            k;
		if (r.kind != K_RD && r.addr == `IFX_REG_INS) begin
			mask = r.data[31:16];
			if (r.data[6:0] == OP_STM) begin
				// One store per set bit starting from the lowest register
				k = 0;
				for (int i = 0; i < 16; i++) begin
					if (mask[i]) begin
						e = '0;
						e.v = 1'b1;
						e.pc = model_pc;
						e.rt = reg_t'(i);
						e.ra = r.data[16:12];
						e.ins = pack_word(OP_ST, e.rt, e.ra, imm_t'(4 * k));
						e.mc = 1'b1;
						exp_ins.push_back(e);
						k++;
					end
				end
			end else begin
				e = '0;
				e.v = 1'b1;
				e.pc = model_pc;
				e.ins = r.data;
				e.rt = r.data[11:7];
				e.ra = r.data[16:12];
				exp_ins.push_back(e);
			end
			model_pc = model_pc + pc_t'(`IFX_PC_STEP);
		end else if (r.kind != K_RD && r.addr == `IFX_REG_IRQ) begin
			// Level 0 is no request at all
			if (r.data[2:0] != 3'd0) begin
				e = '0;
				e.v = 1'b1;
				e.rt = reg_t'(r.data[2:0]);
				e.ins = pack_word(OP_CHK, e.rt, '0, imm_t'(r.data[15:8]));
				exp_irq.push_back(e);
			end
		end else if (r.kind != K_RD && r.addr == `IFX_REG_PC) begin
			model_pc = r.data[15:0];
		end
	endtask

	// ====================
	// Bus driver
	// ====================

	// Setup, then access until pready, then one idle cycle before the next
	task automatic apb_xfer(input logic write, input apb_addr_t addr, input logic [31:0] data,
		input int stall, output apb_rsp_t rsp, output int low);
		logic done;
		low = 0;
		done = 1'b0;
		@(posedge clk);
		#1;
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = write;
		apb.paddr = addr;
		apb.pwdata = data;
		@(posedge clk);
		#1;
		apb.penable = 1'b1;
		while (!done) begin
			@(negedge clk);
			if (apb_rsp.pready) begin
				done = 1'b1;
			end else begin
				low++;
				// Let the extract stage drain once the stall has been seen
				if (stall > 0 && low == stall)
					en_mode = EN_HIGH[1:0];
			end
		end
		rsp = apb_rsp;
		@(posedge clk);
		#1;
		apb = '0;
	endtask

	task automatic drain();
		while (exp_ins.size() != 0 || exp_irq.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk);
	endtask

	task automatic finish_test(input int id);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", id, test_names[id]);
		end else begin
			tests_bad++;
			$display("test %0d %s: %0d errors", id, test_names[id], errors - errors_before);
		end
		errors_before = errors;
	endtask

	// ====================
	// Stimulus table
	// ====================
	task automatic build_table();
		// Plain words and a PC reload
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd1, 5'd2, 15'h0011), 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd3, 5'd4, 15'h0022), 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ST, 5'd5, 5'd6, 15'h0033), 1'b0);
		write_row(K_WR, `IFX_REG_PC, 32'h0000_0200, 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd7, 5'd8, 15'h0044), 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd9, 5'd10, 15'h7FFF), 1'b0);
		control_row(K_DONE, 32'd1);
		// Register lists including one with an empty mask
		write_row(K_WR, `IFX_REG_INS, 32'h8421_3003, 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd1, 5'd1, 15'h0001), 1'b0);
		write_row(K_WR, `IFX_REG_INS, 32'hFFFF_0003, 1'b0);
		write_row(K_WR, `IFX_REG_INS, 32'h0000_2003, 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd2, 5'd2, 15'h0002), 1'b0);
		control_row(K_DONE, 32'd2);
		// Interrupts with one landing on a long list
		write_row(K_WR, `IFX_REG_IRQ, 32'h0000_5A03, 1'b0);
		control_row(K_DRAIN, 32'd0);
		write_row(K_WR, `IFX_REG_IRQ, 32'h0000_7700, 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd4, 5'd4, 15'h0004), 1'b0);
		write_row(K_WR, `IFX_REG_INS, 32'hFFFF_1003, 1'b0);
		write_row(K_WR, `IFX_REG_IRQ, 32'h0000_C307, 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd5, 5'd5, 15'h0005), 1'b0);
		control_row(K_DONE, 32'd3);
		// Fill the queue with the consumer stopped so that the fifth word must wait
		control_row(K_EN, EN_LOW);
		for (int i = 0; i < 4; i++)
			write_row(K_WR, `IFX_REG_INS,
				pack_word(OP_ADD, reg_t'(10 + i), 5'd3, imm_t'(i)), 1'b0);
		write_row(K_WR_STALL, `IFX_REG_INS, pack_word(OP_ADD, 5'd14, 5'd3, 15'h0E), 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd15, 5'd3, 15'h0F), 1'b0);
		control_row(K_EN, EN_RAND);
		control_row(K_DONE, 32'd4);
		// Status count and rejected accesses
		control_row(K_EN, EN_LOW);
		read_row(`IFX_REG_STATUS, 1'b0, 32'd0, 1'b1);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd16, 5'd1, 15'h10), 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd17, 5'd1, 15'h11), 1'b0);
		read_row(`IFX_REG_STATUS, 1'b0, 32'd2, 1'b1);
		read_row(`IFX_REG_INS, 1'b1, 32'd0, 1'b0);
		read_row(`IFX_REG_IRQ, 1'b1, 32'd0, 1'b0);
		read_row(`IFX_REG_PC, 1'b1, 32'd0, 1'b0);
		write_row(K_WR, `IFX_REG_STATUS, 32'h0000_1234, 1'b1);
		write_row(K_WR, 4'h2, pack_word(OP_ADD, 5'd30, 5'd30, 15'h1E), 1'b1);
		read_row(4'h6, 1'b1, 32'd0, 1'b0);
		read_row(`IFX_REG_STATUS, 1'b0, 32'd2, 1'b1);
		control_row(K_EN, EN_RAND);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd18, 5'd1, 15'h12), 1'b0);
		control_row(K_DONE, 32'd5);
		// Mixed stream across a PC wrap
		write_row(K_WR, `IFX_REG_PC, 32'h0000_FFF8, 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd20, 5'd21, 15'h0123), 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_NOP, 5'd3, 5'd3, 15'h0003), 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(7'h55, 5'd22, 5'd23, 15'h4321), 1'b0);
		write_row(K_WR, `IFX_REG_INS, 32'h0003_5003, 1'b0);
		write_row(K_WR, `IFX_REG_IRQ, 32'h0000_1102, 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd24, 5'd25, 15'h0456), 1'b0);
		write_row(K_WR, `IFX_REG_INS, 32'h0100_0003, 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ST, 5'd26, 5'd27, 15'h0789), 1'b0);
		write_row(K_WR, `IFX_REG_INS, pack_word(OP_ADD, 5'd28, 5'd29, 15'h0ABC), 1'b0);
		control_row(K_DONE, 32'd6);
	endtask

	// ====================
	// Stall generator, collector and timeout
	// ====================

	// Two LFSR bits per cycle and en is low only when both are zero
	always @(posedge clk) begin : stall_gen
		logic b0;
		logic b1;
		#1;
		if (en_mode == EN_LOW[1:0]) begin
			en = 1'b0;
		end else if (en_mode == EN_HIGH[1:0]) begin
			en = 1'b1;
		end else begin
			lfsr = lfsr_step(lfsr);
			b0 = lfsr[0];
			lfsr = lfsr_step(lfsr);
			b1 = lfsr[0];
			en = b0 | b1;
		end
	end

	// ins only moves on edges where en was high
	always @(posedge clk)
		en_at_edge <= en && !rst;

	always @(negedge clk) begin : collect
		pipeline_reg_t e;
		if (en_at_edge && !ins.nop) begin
			if (ins.ins[6:0] == OP_CHK) begin
				if (exp_irq.size() == 0) begin
					report_err("unexpected interrupt check on ins");
				end else begin
					// Front entry with a nonzero offset means a list is mid-sequence
					if (exp_ins.size() != 0 && exp_ins[0].mc && exp_ins[0].ins[31:17] != '0)
						report_err("interrupt check inside a register list");
					e = exp_irq.pop_front();
					check_ins(ins, e, "interrupt check");
				end
			end else if (exp_ins.size() == 0) begin
				report_err($sformatf("unexpected instruction %h at pc %h", ins.ins, ins.pc));
			end else begin
				e = exp_ins.pop_front();
				check_ins(ins, e, "instruction");
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	// ====================
	// Main sequence
	// ====================
	initial begin : main
		apb_rsp_t      got;
		apb_rsp_t      exp;
		pipeline_reg_t rst_nop;
		row_t          r;
		int            low;
		apb = '0;
		en = 1'b0;
		en_mode = EN_LOW[1:0];
		lfsr = 16'd32815;
		model_pc = `IFX_RESET_PC;
		test_names[0] = "reset state";
		test_names[1] = "plain stream and pc load";
		test_names[2] = "register list expansion";
		test_names[3] = "interrupt insertion";
		test_names[4] = "full queue stall";
		test_names[5] = "status and bad accesses";
		test_names[6] = "mixed stream with random stalls";
		build_table();
		cycle_limit = 40 * rows.size() + 200;

		wait (rst === 1'b0);
		@(negedge clk);
		rst_nop = '0;
		rst_nop.v = 1'b1;
		rst_nop.nop = 1'b1;
		check_ins(ins, rst_nop, "after reset");
		finish_test(0);
		en_mode = EN_RAND[1:0];

		foreach (rows[i]) begin
			r = rows[i];
			case (r.kind)
				K_WR, K_RD, K_WR_STALL: begin
					model_apply(r);
					apb_xfer(r.kind != K_RD, r.addr, r.data,
						(r.kind == K_WR_STALL) ? STALL_CYCLES : 0, got, low);
					exp = '{prdata: r.exp_rdata, pready: 1'b1, pslverr: r.exp_err};
					check_rsp(got, exp, r.check_data, $sformatf("row %0d response", i));
					if (r.kind == K_WR_STALL && low < STALL_CYCLES) begin
						$display("pready came back while the queue was still full");
						errors++;
					end
				end
				K_EN: begin
					@(negedge clk);
					en_mode = r.data[1:0];
				end
				K_DRAIN: drain();
				K_DONE: begin
					drain();
					finish_test(int'(r.data));
				end
				default: report_err("unknown table row");
			endcase
		end

		$display("summary: %0d of %0d tests ok, %0d errors", tests_run - tests_bad,
			tests_run, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/ifx_clock_gen.sv
// Testbench clock and reset
// Free running clock with a period of 4 and a reset held for 5 cycles

`default_nettype none

module ifx_clock_gen (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset drops a little after the fifth rising edge
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: logic/ifx_top.sv
// Instruction extract top level
// APB front end feeding the instruction queue, drained by the extract stage

`default_nettype none

module ifx_top
	import ifx_isa_pkg::*;
	import ifx_pipe_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  apb_req_t      apb,
	input  logic          en,
	output apb_rsp_t      apb_rsp,
	output pipeline_reg_t ins
);
	// Front end to queue
	logic          push;
	pipeline_reg_t push_ins;
	logic          full;
	queue_count_t  count;

	// Queue to extract stage
	pipeline_reg_t head;
	logic          empty;
	logic          pop;

	// Interrupt request and acknowledge
	irq_level_t    irq_level;
	vector_t       irq_vector;
	logic          irq_ack;

	ifx_apb_front i_ifx_apb_front (
		.clk, .rst, .apb, .full, .count, .irq_ack,
		.apb_rsp, .push, .push_ins, .irq_level, .irq_vector
	);

	ifx_ins_queue i_ifx_ins_queue (
		.clk, .rst, .push, .push_ins, .pop,
		.head, .empty, .full, .count
	);

	ifx_extract_mux i_ifx_extract_mux (
		.clk, .rst, .en, .head, .empty, .irq_level, .irq_vector,
		.pop, .irq_ack, .ins
	);

endmodule

`default_nettype wire

// File: logic/ifx_extract_mux.sv
// Instruction extract stage
// Registers the next instruction for the decoder, choosing between a pending
// interrupt check, a register-list store micro-op, a NOP or the queue head

`default_nettype none

module ifx_extract_mux
	import ifx_isa_pkg::*;
	import ifx_pipe_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          en,
	input  pipeline_reg_t head,
	input  logic          empty,
	input  irq_level_t    irq_level,
	input  vector_t       irq_vector,
	output logic          pop,
	output logic          irq_ack,
	output pipeline_reg_t ins
);
	typedef enum logic {
		MX_PASS,
		MX_LIST
	} mx_state_e;

	mx_state_e     state_q;
	mx_state_e     state_d;
	reg_mask_t     rem_q;
	reg_mask_t     rem_d;
	logic [3:0]    idx_q;
	logic [3:0]    idx_d;
	reg_mask_t     cur_mask;
	logic [3:0]    cur_idx;
	reg_mask_t     cur_rest;
	pipeline_reg_t chk_ins;
	pipeline_reg_t uop_ins;
	pipeline_reg_t ins_d;

	// Register number of the lowest set bit in a list
	function automatic reg_t lowest_reg(input reg_mask_t m);
		reg_t r;
		r = '0;
		for (int i = 15; i >= 0; i--)
			if (m[i])
				r = reg_t'(i);
		return r;
	endfunction

	// ====================
	// Candidate instructions
	// ====================

	// Interrupt check carries the vector in the immediate and the level in rt
	always_comb begin
		chk_ins = '0;
		chk_ins.v = 1'b1;
		chk_ins.ins = make_ins(OP_CHK, reg_t'(irq_level), '0, imm_t'(irq_vector));
		chk_ins.rt = reg_t'(irq_level);
	end

	// The first micro-op reads the list from the head, the rest from rem_q
	assign cur_mask = (state_q == MX_LIST) ? rem_q : ins_mask(head.ins);
	assign cur_idx = (state_q == MX_LIST) ? idx_q : 4'd0;
	assign cur_rest = cur_mask & (cur_mask - 1'b1);

	// Single-register store with the offset stepping by 4
	always_comb begin
		uop_ins = '0;
		uop_ins.v = 1'b1;
		uop_ins.pc = head.pc;
		uop_ins.rt = lowest_reg(cur_mask);
		uop_ins.ra = head.ra;
		uop_ins.ins = make_ins(OP_ST, uop_ins.rt, head.ra, imm_t'({cur_idx, 2'b00}));
		uop_ins.mc = 1'b1;
	end

	// ====================
	// Selection
	// ====================
	always_comb begin
		state_d = state_q;
		rem_d = rem_q;
		idx_d = idx_q;
		ins_d = ins;
		pop = 1'b0;
		irq_ack = 1'b0;
		if (en) begin
			if (state_q == MX_PASS && irq_level != '0) begin
				// Interrupts wait until a list expansion has finished
				ins_d = chk_ins;
				irq_ack = 1'b1;
			end else if (state_q == MX_LIST || (!empty && ins_opcode(head.ins) == OP_STM)) begin
				if (cur_mask == '0) begin
					// Empty list drops out as a bubble
					ins_d = nop_reg();
					pop = 1'b1;
				end else begin
					ins_d = uop_ins;
					rem_d = cur_rest;
					idx_d = cur_idx + 1'b1;
					pop = cur_rest == '0;
					state_d = (cur_rest == '0) ? MX_PASS : MX_LIST;
				end
			end else if (empty) begin
				ins_d = nop_reg();
			end else begin
				ins_d = head;
				pop = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= MX_PASS;
			rem_q <= '0;
			idx_q <= '0;
			ins <= nop_reg();
		end else if (en) begin
			state_q <= state_d;
			rem_q <= rem_d;
			idx_q <= idx_d;
			ins <= ins_d;
		end
	end

endmodule

`default_nettype wire

// File: logic/ifx_ins_queue.sv
// Instruction queue
// Circular buffer of pipeline registers between the APB front end and the
// extract stage, with occupancy count and full and empty flags

`default_nettype none

`include "ifx_settings.svh"

module ifx_ins_queue
	import ifx_pipe_pkg::*;
#(
	parameter int DEPTH = `IFX_QUEUE_DEPTH
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          push,
	input  pipeline_reg_t push_ins,
	input  logic          pop,
	output pipeline_reg_t head,
	output logic          empty,
	output logic          full,
	output queue_count_t  count
);
	localparam int PW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	pipeline_reg_t mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] occ;
	logic          do_push;
	logic          do_pop;

	// A push into a full queue is fine when the head leaves on the same edge
	assign do_pop = pop && !empty;
	assign do_push = push && (!full || do_pop);

	assign empty = occ == '0;
	assign full = occ == CW'(DEPTH);
	assign count = queue_count_t'(occ);
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ <= '0;
		end else begin
			// Pointers wrap by compare so any depth works
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				occ <= occ + 1'b1;
			else if (do_pop && !do_push)
				occ <= occ - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_ins;
	end

endmodule

`default_nettype wire

// File: logic/ifx_apb_front.sv
// APB register front end
// Tags instruction words written to INS with the next PC and pushes them
// into the queue, latches interrupt requests and loads the next PC

`default_nettype none

`include "ifx_settings.svh"

module ifx_apb_front
	import ifx_isa_pkg::*;
	import ifx_pipe_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  apb_req_t      apb,
	input  logic          full,
	input  queue_count_t  count,
	input  logic          irq_ack,
	output apb_rsp_t      apb_rsp,
	output logic          push,
	output pipeline_reg_t push_ins,
	output irq_level_t    irq_level,
	output vector_t       irq_vector
);
	pc_t        next_pc;
	logic       pready_q;
	logic       pslverr_q;
	apb_data_t  prdata_q;
	logic       start;
	logic       complete;
	logic       room;
	logic       accept;
	logic       wr_ins;
	logic       wr_irq;
	logic       wr_pc;
	logic       rd_status;
	irq_level_t new_level;

	// ====================
	// Access decode
	// ====================

	// Setup phase or an access phase that has not been acknowledged yet
	assign start = apb.psel && (!apb.penable || !pready_q);
	assign complete = apb.psel && apb.penable && pready_q;

	assign wr_ins = apb.pwrite && apb.paddr == `IFX_REG_INS;
	assign wr_irq = apb.pwrite && apb.paddr == `IFX_REG_IRQ;
	assign wr_pc = apb.pwrite && apb.paddr == `IFX_REG_PC;
	assign rd_status = !apb.pwrite && apb.paddr == `IFX_REG_STATUS;

	// A push still in flight takes the last free slot
	assign room = !full && !(push && count == queue_count_t'(`IFX_QUEUE_DEPTH - 1));
	assign accept = start && (!wr_ins || room);
	assign new_level = irq_level_t'(apb.pwdata[2:0]);

	assign apb_rsp = '{prdata: prdata_q, pready: pready_q, pslverr: pslverr_q};

	// ====================
	// Control state
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			pready_q <= 1'b0;
			pslverr_q <= 1'b0;
			push <= 1'b0;
			irq_level <= '0;
			next_pc <= `IFX_RESET_PC;
		end else begin
			// The queue takes the word one edge after the access completes
			push <= complete && wr_ins;
			if (complete && wr_ins)
				next_pc <= next_pc + pc_t'(`IFX_PC_STEP);
			else if (complete && wr_pc)
				next_pc <= pc_t'(apb.pwdata[15:0]);
			// A fresh request beats the acknowledge of the old one
			if (complete && wr_irq && new_level != '0)
				irq_level <= new_level;
			else if (irq_ack)
				irq_level <= '0;
			if (complete) begin
				pready_q <= 1'b0;
				pslverr_q <= 1'b0;
			end else if (accept) begin
				pready_q <= 1'b1;
				pslverr_q <= !(wr_ins || wr_irq || wr_pc || rd_status);
			end
		end
	end

	// Read data and tagged instruction payload
	always_ff @(posedge clk) begin
		if (accept)
			prdata_q <= rd_status ? apb_data_t'(count) : '0;
		if (complete && wr_ins) begin
			push_ins.v <= 1'b1;
			push_ins.pc <= next_pc;
			push_ins.ins <= apb.pwdata;
			push_ins.rt <= ins_rt(apb.pwdata);
			push_ins.ra <= ins_ra(apb.pwdata);
			push_ins.nop <= 1'b0;
			push_ins.mc <= 1'b0;
		end
		if (complete && wr_irq && new_level != '0)
			irq_vector <= vector_t'(apb.pwdata[15:8]);
	end

endmodule

`default_nettype wire

// File: logic/ifx_pipe_pkg.sv
// Pipeline and bus package
// Program counter, pipeline register, APB request and response, queue count

`default_nettype none

`include "ifx_settings.svh"

package ifx_pipe_pkg;
	import ifx_isa_pkg::*;

	typedef logic [15:0] pc_t;

	// One slot of the instruction stream, mc marks an expanded micro-op
	typedef struct packed {
		logic      v;
		pc_t       pc;
		ins_word_t ins;
		reg_t      rt;
		reg_t      ra;
		logic      nop;
		logic      mc;
	} pipeline_reg_t;

	typedef logic [3:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	typedef logic [$clog2(`IFX_QUEUE_DEPTH + 1) - 1:0] queue_count_t;

	// Bubble inserted when nothing else is ready
	function automatic pipeline_reg_t nop_reg();
		pipeline_reg_t r;
		r = '0;
		r.v = 1'b1;
		r.ins = make_ins(OP_NOP, '0, '0, '0);
		r.nop = 1'b1;
		return r;
	endfunction

endpackage

`default_nettype wire

// File: logic/ifx_isa_pkg.sv
// Instruction set package
// Opcodes, instruction word layout and field helpers for the extract stage

`default_nettype none

package ifx_isa_pkg;

	// Opcodes known to the extract stage, other codes pass through untouched
	typedef enum logic [6:0] {
		OP_NOP = 7'd0, OP_ADD = 7'd1, OP_ST = 7'd2,
		OP_STM = 7'd3, OP_CHK = 7'd4
	} opcode_e;

	// Word layout is imm[31:17] ra[16:12] rt[11:7] opcode[6:0]
	typedef logic [31:0] ins_word_t;
	typedef logic [4:0]  reg_t;
	typedef logic [14:0] imm_t;
	typedef logic [15:0] reg_mask_t;

	// Interrupt level 0 means no request
	typedef logic [2:0]  irq_level_t;
	typedef logic [7:0]  vector_t;

	function automatic logic [6:0] ins_opcode(input ins_word_t w);
		return w[6:0];
	endfunction

	function automatic reg_t ins_rt(input ins_word_t w);
		return w[11:7];
	endfunction

	function automatic reg_t ins_ra(input ins_word_t w);
		return w[16:12];
	endfunction

	// A store-multiple keeps its list in the top half, so mask bit 0 shares
	// the top bit of ra
	function automatic reg_mask_t ins_mask(input ins_word_t w);
		return w[31:16];
	endfunction

	function automatic ins_word_t make_ins(input opcode_e op, input reg_t rt,
		input reg_t ra, input imm_t imm);
		return {imm, ra, rt, op};
	endfunction

endpackage

`default_nettype wire

// File: logic/ifx_settings.svh
// Instruction extract settings
// Queue depth, reset program counter, PC step and the APB register map
// shared by the front end, the queue and the pipeline package

`ifndef IFX_SETTINGS_SVH
`define IFX_SETTINGS_SVH

// Entries held in the instruction queue
`define IFX_QUEUE_DEPTH 4

// PC given to the first word pushed after reset
`define IFX_RESET_PC 16'h0100

// PC increment for each pushed word
`define IFX_PC_STEP 4

// APB register offsets
`define IFX_REG_INS    4'h0
`define IFX_REG_IRQ    4'h4
`define IFX_REG_PC     4'h8
`define IFX_REG_STATUS 4'hC

`endif
